/* verilog/configuration.sv */
package configuration;

  // ----------------------------------------
  // system sizes
  // ----------------------------------------
  localparam int unsigned RAM_ADDRESS_BITWIDTH = 21;  // br_addr, 64-bit line units
  localparam int unsigned CACHE_LINE_INDEX_BITWIDTH = 6;  // 64 lines

  // ----------------------------------------
  // clock and serial
  // ----------------------------------------
  localparam int unsigned CLOCK_FREQUENCY_HZ = 30_000_000;
  localparam int unsigned UART_BAUD_RATE = 115200;

  // behavioral burst ram
  localparam int unsigned BURST_RAM_READ_LATENCY = 4;  // cmd to rd_data_valid

endpackage

/* verilog/ramio_types_pkg.sv */
package ramio_types_pkg;

  // ----------------------------------------
  // request port access types
  // ----------------------------------------
  typedef enum logic [1:0] {
    WR_NONE,
    WR_BYTE,
    WR_HALF,
    WR_WORD
  } write_type_e;

  // byte and half reads sign-extend unless _U
  typedef enum logic [2:0] {
    RD_NONE,
    RD_BYTE,
    RD_HALF,
    RD_WORD,
    RD_BYTE_U,
    RD_HALF_U
  } read_type_e;

  // ----------------------------------------
  // burst ram command
  // ----------------------------------------
  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_cmd_e;

  localparam int unsigned BR_ADDR_BITS = configuration::RAM_ADDRESS_BITWIDTH;

  typedef struct packed {
    br_cmd_e                 cmd;
    logic [BR_ADDR_BITS-1:0] addr;       // line address
    logic [63:0]             wr_data;
    logic [7:0]              data_mask;  // set bit keeps that byte
  } br_req_t;

  // memory mapped i/o at the top of the space
  localparam logic [31:0] ADDR_LED = 32'hFFFF_FFFF;
  localparam logic [31:0] ADDR_UART_OUT = 32'hFFFF_FFFE;
  localparam logic [31:0] ADDR_UART_IN = 32'hFFFF_FFFD;

endpackage

/* verilog/burst_ram.sv */
module burst_ram #(
    parameter int unsigned RamAddressBitWidth = configuration::RAM_ADDRESS_BITWIDTH,
    parameter int unsigned ReadLatency = configuration::BURST_RAM_READ_LATENCY
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ramio_types_pkg::br_req_t br_req,
    input  logic                     br_cmd_en,
    output logic              [63:0] br_rd_data,
    output logic                     br_rd_data_valid
);
  import ramio_types_pkg::*;

  // depth capped for simulation, address wraps
  localparam int unsigned DepthBits = (RamAddressBitWidth < 12) ? RamAddressBitWidth : 12;

  logic [63:0] mem[2**DepthBits];
  logic [DepthBits-1:0] idx;
  logic [63:0] data_pipe[ReadLatency];  // read latency pipe
  logic [ReadLatency-1:0] valid_pipe;

  assign idx = br_req.addr[DepthBits-1:0];
  assign br_rd_data = data_pipe[ReadLatency-1];
  assign br_rd_data_valid = valid_pipe[ReadLatency-1];

  always_ff @(posedge clk) begin
    if (br_cmd_en && br_req.cmd == BR_WRITE) begin
      for (int b = 0; b < 8; b++) begin
        if (!br_req.data_mask[b]) begin
          mem[idx][b*8+:8] <= br_req.wr_data[b*8+:8];
        end
      end
    end
    data_pipe[0] <= mem[idx];  // sampled every cycle, valid says when
    for (int i = 1; i < ReadLatency; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= br_cmd_en && br_req.cmd == BR_READ;
      for (int i = 1; i < ReadLatency; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  a_cmd_en_known : assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(br_cmd_en) && (br_cmd_en -> !$isunknown(br_req.cmd)))
    else $error("burst ram command strobe unknown");

endmodule

/* verilog/cache.sv */
module cache #(
    parameter int unsigned CacheLineIndexBitWidth = configuration::CACHE_LINE_INDEX_BITWIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_enable,
    input  ramio_types_pkg::write_type_e write_type,
    input  ramio_types_pkg::read_type_e  read_type,
    input  logic                  [31:0] address,
    input  logic                  [31:0] wdata,
    output logic                  [31:0] rdata,
    output logic                         done,
    output ramio_types_pkg::br_req_t     br_req,
    output logic                         br_cmd_en,
    input  logic                  [63:0] br_rd_data,
    input  logic                         br_rd_data_valid
);
  import ramio_types_pkg::*;

  localparam int unsigned Lines = 2 ** CacheLineIndexBitWidth;
  localparam int unsigned TagBits = 29 - CacheLineIndexBitWidth;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    EVICT,
    FILL_WAIT
  } cache_state_e;

  cache_state_e state_q;

  // request held for the whole access
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  write_type_e wtype_q;
  read_type_e rtype_q;

  // per line storage
  logic [TagBits-1:0] tag_mem[Lines];
  logic [63:0] data_mem[Lines];
  logic [Lines-1:0] valid_q;
  logic [Lines-1:0] dirty_q;

  logic [2:0] off;
  logic [CacheLineIndexBitWidth-1:0] idx;
  logic [TagBits-1:0] tag;
  logic [63:0] line;
  logic hit;
  logic [28:0] evict_line;
  logic [28:0] fill_line;
  logic [7:0] be;
  logic [63:0] wpat;
  logic [63:0] merged;
  logic [63:0] shifted;
  logic [3:0] req_bytes;

  assign off = addr_q[2:0];
  assign idx = addr_q[3+:CacheLineIndexBitWidth];
  assign tag = addr_q[31-:TagBits];
  assign line = data_mem[idx];
  assign hit = valid_q[idx] && tag_mem[idx] == tag;
  assign done = state_q == LOOKUP && hit;  // one cycle after request on a hit
  assign evict_line = {tag_mem[idx], idx};
  assign fill_line = addr_q[31:3];

  // ----------------------------------------
  // burst ram commands
  // ----------------------------------------
  always_comb begin
    br_req = '{cmd: BR_READ, addr: fill_line[BR_ADDR_BITS-1:0], wr_data: line, data_mask: 8'h00};
    br_cmd_en = 1'b0;
    if (state_q == EVICT) begin
      br_req.cmd = BR_WRITE;  // write back old line
      br_req.addr = evict_line[BR_ADDR_BITS-1:0];
      br_cmd_en = 1'b1;
    end else if (state_q == LOOKUP && !hit && !dirty_q[idx]) begin
      br_cmd_en = 1'b1;  // clean miss, fetch
    end
  end

  // write merge into the line
  always_comb begin
    wpat = {32'h0, wdata_q} << {off, 3'b000};
    case (wtype_q)
      WR_BYTE: be = 8'h01 << off;
      WR_HALF: be = 8'h03 << off;
      WR_WORD: be = 8'h0f << off;
      default: be = 8'h00;
    endcase
    for (int b = 0; b < 8; b++) begin
      merged[b*8+:8] = be[b] ? wpat[b*8+:8] : line[b*8+:8];
    end
  end

  // read extract and extend
  always_comb begin
    shifted = line >> {off, 3'b000};
    case (rtype_q)
      RD_BYTE: rdata = {{24{shifted[7]}}, shifted[7:0]};
      RD_HALF: rdata = {{16{shifted[15]}}, shifted[15:0]};
      RD_BYTE_U: rdata = {24'h0, shifted[7:0]};
      RD_HALF_U: rdata = {16'h0, shifted[15:0]};
      default: rdata = shifted[31:0];
    endcase
  end

  // ----------------------------------------
  // state
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (req_enable) state_q <= LOOKUP;
        LOOKUP: begin
          if (hit) begin
            state_q <= IDLE;
            if (wtype_q != WR_NONE) dirty_q[idx] <= 1'b1;
          end else if (dirty_q[idx]) begin
            state_q <= EVICT;
          end else begin
            state_q <= FILL_WAIT;  // read issued this cycle
          end
        end
        EVICT: begin
          dirty_q[idx] <= 1'b0;  // write done in cmd cycle
          state_q <= LOOKUP;  // misses again, now clean
        end
        FILL_WAIT: begin
          if (br_rd_data_valid) begin
            valid_q[idx] <= 1'b1;
            state_q <= LOOKUP;  // retry, hits
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_enable) begin
      addr_q <= address;
      wdata_q <= wdata;
      wtype_q <= write_type;
      rtype_q <= read_type;
    end
    if (done && wtype_q != WR_NONE) data_mem[idx] <= merged;
    if (state_q == FILL_WAIT && br_rd_data_valid) begin
      data_mem[idx] <= br_rd_data;
      tag_mem[idx] <= tag;
    end
  end

  // access size at the request port
  always_comb begin
    if (write_type == WR_BYTE || read_type inside {RD_BYTE, RD_BYTE_U}) req_bytes = 4'd1;
    else if (write_type == WR_HALF || read_type inside {RD_HALF, RD_HALF_U}) req_bytes = 4'd2;
    else req_bytes = 4'd4;
  end

  a_no_line_cross : assert property (@(posedge clk) disable iff (!rst_n)
      req_enable |-> ({1'b0, address[2:0]} + req_bytes) <= 4'd8)
    else $error("access crosses a cache line");

endmodule

/* verilog/uart_tx.sv */
module uart_tx #(
    parameter int unsigned ClockFrequencyHz = configuration::CLOCK_FREQUENCY_HZ,
    parameter int unsigned BaudRate = configuration::UART_BAUD_RATE
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] data,
    input  logic       start,
    output logic       tx_busy,
    output logic       tx
);

  localparam int unsigned BitCycles = ClockFrequencyHz / BaudRate;
  localparam int unsigned CntBits = $clog2(BitCycles) + 1;

  logic [CntBits-1:0] cnt_q;  // cycles within a bit
  logic [3:0] bits_q;  // bits sent so far
  logic [8:0] shift_q;  // data then stop
  logic bit_end;

  assign bit_end = cnt_q == CntBits'(BitCycles - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      tx <= 1'b1;  // line idles high
      cnt_q <= '0;
      bits_q <= '0;
    end else if (!tx_busy) begin
      if (start) begin
        tx_busy <= 1'b1;
        tx <= 1'b0;  // start bit
        cnt_q <= '0;
        bits_q <= '0;
      end
    end else if (bit_end) begin
      cnt_q <= '0;
      if (bits_q == 4'd9) begin
        tx_busy <= 1'b0;  // stop bit finished
      end else begin
        tx <= shift_q[0];  // lsb first
        bits_q <= bits_q + 4'd1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!tx_busy && start) shift_q <= {1'b1, data};
    else if (tx_busy && bit_end) shift_q <= {1'b0, shift_q[8:1]};
  end

endmodule

/* verilog/uart_rx.sv */
module uart_rx #(
    parameter int unsigned ClockFrequencyHz = configuration::CLOCK_FREQUENCY_HZ,
    parameter int unsigned BaudRate = configuration::UART_BAUD_RATE
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    input  logic       clear,
    output logic [7:0] byte_out,
    output logic       byte_valid
);

  localparam int unsigned BitCycles = ClockFrequencyHz / BaudRate;
  localparam int unsigned CntBits = $clog2(BitCycles) + 1;

  logic rx_meta_q;
  logic rx_s_q;  // synchronized line
  logic active_q;
  logic [CntBits-1:0] cnt_q;
  logic [3:0] bits_q;  // 0 start, 1..8 data, 9 stop
  logic [7:0] shift_q;
  logic tick;  // mid-bit sample point

  assign tick = active_q && cnt_q == '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta_q <= 1'b1;
      rx_s_q <= 1'b1;
      active_q <= 1'b0;
      cnt_q <= '0;
      bits_q <= '0;
      byte_valid <= 1'b0;
    end else begin
      rx_meta_q <= rx;
      rx_s_q <= rx_meta_q;
      if (clear) byte_valid <= 1'b0;
      if (!active_q) begin
        if (!rx_s_q) begin
          active_q <= 1'b1;  // falling edge, start bit
          cnt_q <= CntBits'(BitCycles / 2 - 1);  // half bit to mid
          bits_q <= '0;
        end
      end else if (!tick) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= CntBits'(BitCycles - 1);
        bits_q <= bits_q + 4'd1;
        if (bits_q == 4'd0 && rx_s_q) active_q <= 1'b0;  // glitch, not a start
        if (bits_q == 4'd9) begin
          active_q <= 1'b0;
          if (rx_s_q) byte_valid <= 1'b1;  // good stop bit, wins over clear
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tick && bits_q inside {[4'd1 : 4'd8]}) shift_q <= {rx_s_q, shift_q[7:1]};
    if (tick && bits_q == 4'd9 && rx_s_q) byte_out <= shift_q;  // overwrites old byte
  end

endmodule

/* verilog/ramio.sv */
module ramio #(
    parameter int unsigned ClockFrequencyHz = configuration::CLOCK_FREQUENCY_HZ,
    parameter int unsigned BaudRate = configuration::UART_BAUD_RATE,
    parameter int unsigned CacheLineIndexBitWidth = configuration::CACHE_LINE_INDEX_BITWIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  ramio_types_pkg::write_type_e write_type,
    input  ramio_types_pkg::read_type_e  read_type,
    input  logic                  [31:0] address,
    input  logic                  [31:0] data_in,
    output logic                  [31:0] data_out,
    output logic                         data_out_ready,
    output logic                         busy,
    output logic                  [ 3:0] led,
    input  logic                         uart_rx,
    output logic                         uart_tx,
    output ramio_types_pkg::br_req_t     br_req,
    output logic                         br_cmd_en,
    input  logic                  [63:0] br_rd_data,
    input  logic                         br_rd_data_valid
);
  import ramio_types_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CACHE,
    UART_WAIT
  } ramio_state_e;

  ramio_state_e state_q;
  logic is_read_q;  // access returns data
  logic [31:0] req_addr_q;
  logic [31:0] req_data_q;
  write_type_e req_wtype_q;
  read_type_e req_rtype_q;
  logic cache_enable_q;
  logic [31:0] cache_rdata;
  logic cache_done;
  logic tx_start;
  logic tx_busy;
  logic [7:0] rx_byte;
  logic rx_valid;
  logic rx_clear;
  logic accept;
  logic finish;
  logic to_cache;
  logic is_read;
  logic is_write;
  logic [31:0] io_rdata;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  assign accept = enable && state_q == IDLE && !busy;
  assign is_read = read_type != RD_NONE;
  assign is_write = write_type != WR_NONE;
  assign to_cache = address != ADDR_LED && address != ADDR_UART_OUT && address != ADDR_UART_IN;
  assign io_rdata = (address == ADDR_UART_IN && rx_valid) ? {24'h0, rx_byte} : 32'hFFFF_FFFF;
  assign rx_clear = accept && is_read && address == ADDR_UART_IN;  // read empties the buffer
  assign tx_start = state_q == UART_WAIT && !tx_busy;  // waits out a running frame

  always_comb begin
    case (state_q)
      CACHE: finish = cache_done;
      UART_WAIT: finish = !tx_busy;
      default: finish = busy;  // one cycle i/o access ending
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      cache_enable_q <= 1'b0;
      is_read_q <= 1'b0;
      led <= '0;
    end else begin
      cache_enable_q <= 1'b0;
      data_out_ready <= finish && is_read_q;  // same edge busy falls
      if (finish) busy <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            busy <= 1'b1;
            is_read_q <= is_read;
            if (to_cache) begin
              state_q <= CACHE;
              cache_enable_q <= 1'b1;
            end else if (address == ADDR_UART_OUT && is_write) begin
              state_q <= UART_WAIT;
            end else if (address == ADDR_LED && is_write) begin
              led <= data_in[3:0];
            end
          end
        end
        CACHE, UART_WAIT: if (finish) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q <= address;
      req_data_q <= data_in;
      req_wtype_q <= write_type;
      req_rtype_q <= read_type;
    end
    if (accept && !to_cache && is_read) data_out <= io_rdata;
    if (state_q == CACHE && cache_done && is_read_q) data_out <= cache_rdata;
  end

  // ----------------------------------------
  // submodules
  // ----------------------------------------
  cache #(
      .CacheLineIndexBitWidth(CacheLineIndexBitWidth)
  ) u_cache (
      .clk,
      .rst_n,
      .req_enable(cache_enable_q),
      .write_type(req_wtype_q),
      .read_type(req_rtype_q),
      .address(req_addr_q),
      .wdata(req_data_q),
      .rdata(cache_rdata),
      .done(cache_done),
      .br_req,
      .br_cmd_en,
      .br_rd_data,
      .br_rd_data_valid
  );

  uart_tx #(
      .ClockFrequencyHz(ClockFrequencyHz),
      .BaudRate(BaudRate)
  ) u_uart_tx (
      .clk,
      .rst_n,
      .data(req_data_q[7:0]),
      .start(tx_start),
      .tx_busy,
      .tx(uart_tx)
  );

  uart_rx #(
      .ClockFrequencyHz(ClockFrequencyHz),
      .BaudRate(BaudRate)
  ) u_uart_rx (
      .clk,
      .rst_n,
      .rx(uart_rx),
      .clear(rx_clear),
      .byte_out(rx_byte),
      .byte_valid(rx_valid)
  );

  a_enable_not_busy : assert property (@(posedge clk) disable iff (!rst_n) enable |-> !busy)
    else $error("enable while busy");

  a_one_access_type : assert property (@(posedge clk) disable iff (!rst_n)
      enable |-> !(is_read && is_write))
    else $error("read and write in one request");

endmodule

/* verilog/top.sv */
module top #(
    parameter int unsigned ClockFrequencyHz = configuration::CLOCK_FREQUENCY_HZ,
    parameter int unsigned BaudRate = configuration::UART_BAUD_RATE,
    parameter int unsigned CacheLineIndexBitWidth = configuration::CACHE_LINE_INDEX_BITWIDTH,
    parameter int unsigned RamAddressBitWidth = configuration::RAM_ADDRESS_BITWIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  ramio_types_pkg::write_type_e write_type,
    input  ramio_types_pkg::read_type_e  read_type,
    input  logic                  [31:0] address,
    input  logic                  [31:0] data_in,
    output logic                  [31:0] data_out,
    output logic                         data_out_ready,
    output logic                         busy,
    output logic                  [ 5:0] led,
    input  logic                         uart_rx,
    output logic                         uart_tx
);
  import configuration::*;
  import ramio_types_pkg::*;

  localparam int unsigned HeartbeatCycles = ClockFrequencyHz / 2;  // toggle every half second

  // burst ram wiring
  br_req_t br_req;
  logic br_cmd_en;
  logic [63:0] br_rd_data;
  logic br_rd_data_valid;

  logic [31:0] beat_cnt_q;
  logic beat_q;

  ramio #(
      .ClockFrequencyHz(ClockFrequencyHz),
      .BaudRate(BaudRate),
      .CacheLineIndexBitWidth(CacheLineIndexBitWidth)
  ) u_ramio (
      .clk,
      .rst_n,
      .enable,
      .write_type,
      .read_type,
      .address,
      .data_in,
      .data_out,
      .data_out_ready,
      .busy,
      .led(led[4:1]),
      .uart_rx,
      .uart_tx,
      .br_req,
      .br_cmd_en,
      .br_rd_data,
      .br_rd_data_valid
  );

  burst_ram #(
      .RamAddressBitWidth(RamAddressBitWidth),
      .ReadLatency(BURST_RAM_READ_LATENCY)
  ) u_burst_ram (
      .clk,
      .rst_n,
      .br_req,
      .br_cmd_en,
      .br_rd_data,
      .br_rd_data_valid
  );

  // ----------------------------------------
  // heartbeat on led[0]
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
      beat_q <= 1'b0;
    end else if (beat_cnt_q == HeartbeatCycles - 1) begin
      beat_cnt_q <= '0;
      beat_q <= ~beat_q;
    end else begin
      beat_cnt_q <= beat_cnt_q + 32'd1;
    end
  end

  assign led[0] = beat_q;
  assign led[5] = ~busy;  // lit while idle

endmodule

/* dv/tb_top.sv */
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import ramio_types_pkg::*;

  localparam int unsigned ClockHz = 25_000_000;
  localparam int unsigned Baud = 1_562_500;
  localparam int unsigned BitCycles = ClockHz / Baud;  // 16 cycles per bit
  localparam int unsigned BusyTimeout = 400;  // covers a full uart frame of back-pressure
  localparam int unsigned StartTimeout = 400;

  logic clk;
  logic rst_n;
  logic enable;
  write_type_e write_type;
  read_type_e read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic data_out_ready;
  logic busy;
  logic [5:0] led;
  logic uart_rx;
  logic uart_tx;

  logic [31:0] last_rdata;  // data_out holds this until the next read
  logic have_read;
  int unsigned beat_cycles;  // clocks since reset release

  top #(
      .ClockFrequencyHz(ClockHz),
      .BaudRate(Baud)
  ) dut (
      .clk,
      .rst_n,
      .enable,
      .write_type,
      .read_type,
      .address,
      .data_in,
      .data_out,
      .data_out_ready,
      .busy,
      .led,
      .uart_rx,
      .uart_tx
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cycles <= 0;
    end else begin
      beat_cycles <= beat_cycles + 1;
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  // heartbeat model, led[0] toggles every half second
  function automatic logic heartbeat_level(input int unsigned cycles);
    return ((cycles / (ClockHz / 2)) % 2) != 0;
  endfunction

  task automatic check_heartbeat();
    logic exp_beat;
    exp_beat = heartbeat_level(beat_cycles);
    assert (led[0] == exp_beat)
    else abort_run($sformatf("Mismatch led[0]: got %h expected %h", led[0], exp_beat));
  endtask

  // ----------------------------------------
  // request port
  // ----------------------------------------
  task automatic issue_request(input write_type_e wt, input read_type_e rt,
                               input logic [31:0] addr, input logic [31:0] data);
    assert (!busy) else abort_run("request issued while busy");
    enable = 1'b1;  // one-cycle pulse
    write_type = wt;
    read_type = rt;
    address = addr;
    data_in = data;
    @(negedge clk);
    enable = 1'b0;
    write_type = WR_NONE;
    read_type = RD_NONE;
    assert (busy) else abort_run("busy did not rise the cycle after enable");
    assert (led[5] == 1'b0)
    else abort_run($sformatf("Mismatch led[5]: got %h expected 0 while busy", led[5]));
  endtask

  task automatic wait_not_busy(input logic expect_read);
    int unsigned cycles;
    cycles = 0;
    while (busy) begin
      assert (!data_out_ready) else abort_run("data_out_ready pulsed while busy was high");
      @(negedge clk);
      cycles++;
      assert (cycles <= BusyTimeout) else abort_run("timed out waiting for busy to fall");
    end
    // strobe comes with the falling edge of busy
    assert (data_out_ready == expect_read)
    else abort_run($sformatf("Mismatch data_out_ready: got %h expected %h",
                             data_out_ready, expect_read));
    if (!expect_read && have_read) begin
      assert (data_out == last_rdata)
      else abort_run($sformatf("Mismatch data_out: got %08h expected %08h after a write",
                               data_out, last_rdata));
    end
  endtask

  // ----------------------------------------
  // uart line helpers
  // ----------------------------------------
  task automatic capture_tx_byte(output logic [7:0] b);
    int unsigned cycles;
    cycles = 0;
    while (uart_tx) begin
      @(negedge clk);
      cycles++;
      assert (cycles <= StartTimeout) else abort_run("timed out waiting for a uart_tx start bit");
    end
    repeat (BitCycles / 2) @(negedge clk);  // to the middle of the start bit
    assert (!uart_tx) else abort_run("uart_tx start bit shorter than half a bit");
    for (int i = 0; i < 8; i++) begin
      repeat (BitCycles) @(negedge clk);
      b[i] = uart_tx;  // lsb first
    end
    repeat (BitCycles) @(negedge clk);
    assert (uart_tx) else abort_run("uart_tx stop bit missing");
  endtask

  task automatic drive_rx_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // stop, data, start
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (BitCycles) @(negedge clk);
    end
    uart_rx = 1'b1;
    repeat (BitCycles) @(negedge clk);  // one idle bit so the receiver settles
  endtask

  // ----------------------------------------
  // vector loop
  // ----------------------------------------
  initial begin
    int fd;
    int n;
    int rc;
    int unsigned ops;
    string text;
    logic [7:0] op;
    logic [31:0] typ;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [7:0] tx_byte;

    clk = 1'b0;
    rst_n = 1'b0;
    enable = 1'b0;
    write_type = WR_NONE;
    read_type = RD_NONE;
    address = '0;
    data_in = '0;
    uart_rx = 1'b1;  // idle line
    ops = 0;
    have_read = 1'b0;
    last_rdata = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!busy && !data_out_ready) else abort_run("busy or data_out_ready high after reset");
    assert (uart_tx) else abort_run("uart_tx not idle high after reset");
    check_heartbeat();

    fd = $fopen("dv/ramio_vectors.txt", "r");
    assert (fd != 0) else abort_run("could not open dv/ramio_vectors.txt");
    while (!$feof(fd)) begin
      text = "";
      rc = $fgets(text, fd);
      if (rc == 0) continue;  // nothing left to read
      n = $sscanf(text, "%c %h %h %h %h", op, typ, addr, data, expv);
      if (n != 5 || op == "#") continue;  // comments and blank lines
      ops++;
      case (op)
        "W": begin
          issue_request(write_type_e'(typ[1:0]), RD_NONE, addr, data);
          wait_not_busy(1'b0);
        end
        "R": begin
          issue_request(WR_NONE, read_type_e'(typ[2:0]), addr, '0);
          wait_not_busy(1'b1);
          assert (data_out == expv)
          else abort_run($sformatf("Mismatch data_out: got %08h expected %08h at %08h",
                                   data_out, expv, addr));
          last_rdata = expv;
          have_read = 1'b1;
          @(negedge clk);
          assert (!data_out_ready) else abort_run("data_out_ready longer than one cycle");
        end
        "T": begin
          issue_request(write_type_e'(typ[1:0]), RD_NONE, addr, data);
          wait_not_busy(1'b0);
          capture_tx_byte(tx_byte);
          assert (tx_byte == expv[7:0])
          else abort_run($sformatf("Mismatch uart_tx: got %02h expected %02h",
                                   tx_byte, expv[7:0]));
        end
        "I": drive_rx_byte(data[7:0]);
        "L": begin
          issue_request(write_type_e'(typ[1:0]), RD_NONE, addr, data);
          wait_not_busy(1'b0);
          assert (led[4:1] == expv[3:0])
          else abort_run($sformatf("Mismatch led[4:1]: got %h expected %h", led[4:1], expv[3:0]));
          assert (led[5] == 1'b1)
          else abort_run($sformatf("Mismatch led[5]: got %h expected 1 while idle", led[5]));
          check_heartbeat();
        end
        default: abort_run($sformatf("unknown opcode %c in the vector file", op));
      endcase
    end
    $fclose(fd);

    if (ops == 0) begin
      abort_run("no operations found in dv/ramio_vectors.txt");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

/* ramio_subsys.f */
verilog/configuration.sv
verilog/ramio_types_pkg.sv
verilog/burst_ram.sv
verilog/cache.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/ramio.sv
verilog/top.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build tb_top with Verilator and run it, status is the simulation's own
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_top \
  -f ramio_subsys.f \
  --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_top_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

/* dv/ramio_vectors.txt */
# op type address data expect, all hex except op
# op: W write, R read, T uart out, I uart inject, L led; type is the write or read type code
# uart in with an empty buffer
R 4 FFFFFFFD 00000000 FFFFFFFF
# word write, then byte and half merges into it
W 3 00000100 12345678 00000000
R 3 00000100 00000000 12345678
W 1 00000101 000000AB 00000000
R 3 00000100 00000000 1234AB78
W 2 00000102 0000CDEF 00000000
R 3 00000100 00000000 CDEFAB78
W 3 00000104 80F07F81 00000000
R 3 00000104 00000000 80F07F81
# sign and zero extension
R 1 00000104 00000000 FFFFFF81
R 4 00000104 00000000 00000081
R 1 00000105 00000000 0000007F
R 2 00000106 00000000 FFFF80F0
R 5 00000106 00000000 000080F0
R 2 00000104 00000000 00007F81
R 1 00000103 00000000 FFFFFFCD
R 3 00000102 00000000 7F81CDEF
# same index, other tag, dirty line evicted both ways
W 3 00000300 55AA33CC 00000000
R 3 00000300 00000000 55AA33CC
R 3 00000100 00000000 CDEFAB78
R 3 00000104 00000000 80F07F81
R 3 00000300 00000000 55AA33CC
# clean miss on another line
W 3 00001008 DEADBEEF 00000000
R 5 0000100A 00000000 0000DEAD
# uart out frames, second one waits for the first
T 1 FFFFFFFE 000000A5 000000A5
T 1 FFFFFFFE 0000003C 0000003C
# uart in, one byte then empty again
I 0 FFFFFFFD 0000005A 00000000
R 4 FFFFFFFD 00000000 0000005A
R 4 FFFFFFFD 00000000 FFFFFFFF
# leds
L 3 FFFFFFFF 0000000B 0000000B
L 3 FFFFFFFF 00000004 00000004
